// File: source/cpu_pkg.sv
package cpu_pkg;

    localparam logic [31:0] reset_pc   = 32'h1c00_0000;
    localparam logic [31:0] excp_entry = 32'h1c00_0800;

    // 3R format, inst[31:15]
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 format, inst[31:22]
    localparam logic [9:0]  op_addi_w = 10'h00a;
    localparam logic [9:0]  op_andi   = 10'h00d;
    localparam logic [9:0]  op_ori    = 10'h00e;

    localparam logic [6:0]  op_lu12i_w = 7'h0a;   // 1RI20, inst[31:25]

    // 2RI16 format, inst[31:26]
    localparam logic [5:0]  op_jirl = 6'h13;
    localparam logic [5:0]  op_b    = 6'h14;
    localparam logic [5:0]  op_beq  = 6'h16;
    localparam logic [5:0]  op_bne  = 6'h17;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b              // lu12i.w and jirl link
    } alu_op_e;

    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_r3_t;

    typedef struct packed {
        logic [9:0]  opcode;
        logic [11:0] imm12;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri12_t;

    // b keeps offs[25:16] in the rj/rd fields
    typedef struct packed {
        logic [5:0]  opcode;
        logic [15:0] offs16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } fmt_ri16_t;

    typedef struct packed {
        logic [6:0]  opcode;
        logic [19:0] si20;
        logic [4:0]  rd;
    } fmt_ri20_t;

    typedef union packed {
        fmt_r3_t   r3;
        fmt_ri12_t ri12;
        fmt_ri16_t ri16;
        fmt_ri20_t ri20;
    } inst_word_u;

    typedef struct packed {
        logic        br_taken;
        logic [31:0] br_target;
    } br_bus_t;

    typedef struct packed {
        inst_word_u  inst;
        logic [31:0] pc;
        logic        adef;
    } if_id_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic        rf_we;
        logic [4:0]  dest;
        logic        adef;
    } id_exe_bus_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic        rf_we;
        logic [4:0]  dest;
        logic        adef;
    } exe_wb_bus_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } rf_wr_t;

    typedef struct packed {
        logic        flush;
        logic [31:0] target;
    } flush_t;

endpackage

// File: source/if_stage.sv
`timescale 1ns/1ps

module if_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        id_allowin,
    input  br_bus_t     br,
    input  flush_t      wb_to_if_bus,
    input  logic [31:0] inst_sram_rdata,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    output logic        if_to_id_valid,
    output if_id_bus_t  if_to_id_bus
);

    logic        if_valid;
    logic [31:0] if_pc;
    logic        if_adef;
    logic        if_allowin;
    logic [31:0] seq_pc;
    logic [31:0] pre_pc;       // pre-IF address one cycle ahead of if_pc
    logic        pre_adef;

    assign if_allowin = !if_valid || id_allowin;   // fetch itself is never late

    assign seq_pc = if_pc + 32'd4;
    assign pre_pc = wb_to_if_bus.flush ? wb_to_if_bus.target :
                    br.br_taken        ? br.br_target        :
                                         seq_pc;
    assign pre_adef = |pre_pc[1:0];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
            if_pc    <= reset_pc - 32'd4;
            if_adef  <= 1'b0;
        end else if (wb_to_if_bus.flush) begin
            // restart as after reset so the entry is fetched next cycle
            if_valid <= 1'b0;
            if_pc    <= pre_pc - 32'd4;
            if_adef  <= 1'b0;
        end else if (if_allowin) begin
            if_valid <= 1'b1;
            if_pc    <= pre_pc;
            if_adef  <= pre_adef;
        end
    end

    assign inst_sram_en   = if_allowin && resetn;
    assign inst_sram_addr = pre_pc;

    assign if_to_id_valid = if_valid;
    assign if_to_id_bus   = '{
        inst: inst_sram_rdata,         // held by the SRAM while we stall
        pc:   if_pc,
        adef: if_adef
    };

    // stalled fetch leaves the SRAM idle
    a_stall_holds: assert property (@(posedge clk) disable iff (!resetn)
        (if_valid && !id_allowin) |-> !inst_sram_en);

endmodule

// File: source/id_stage.sv
`timescale 1ns/1ps

module id_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        if_to_id_valid,
    input  if_id_bus_t  if_to_id_bus,
    input  logic        exe_allowin,
    input  rf_wr_t      exe_dest_info,
    input  rf_wr_t      wb_rf,
    input  logic [31:0] rf_rdata1,
    input  logic [31:0] rf_rdata2,
    input  logic        flush,
    output logic        id_allowin,
    output br_bus_t     br,
    output logic [4:0]  rf_raddr1,
    output logic [4:0]  rf_raddr2,
    output logic        id_to_exe_valid,
    output id_exe_bus_t id_to_exe_bus
);

    logic        id_valid;
    logic        id_ready_go;
    if_id_bus_t  id_bus;
    inst_word_u  inst;
    logic        ok;            // decodable when the fetch had no error
    logic        is_add, is_sub, is_and, is_or, is_xor;
    logic        is_addi, is_andi, is_ori, is_lu12i;
    logic        is_beq, is_bne, is_b, is_jirl;
    logic        use_rj;
    logic        use_r2;
    logic        hazard;
    logic [31:0] simm12;
    logic [31:0] zimm12;
    logic [31:0] lu12i_imm;
    logic [31:0] offs16_sh;
    logic [31:0] offs26_sh;
    logic        src_eq;
    logic        br_cond;
    logic        dec_rf_we;
    alu_op_e     dec_alu_op;
    logic [31:0] dec_src_b;

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid && !br.br_taken;   // drop the wrong-path slot
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_bus <= if_to_id_bus;
        end
    end

    assign inst = id_bus.inst;
    assign ok   = !id_bus.adef;

    assign is_add   = ok && inst.r3.opcode == op_add_w;
    assign is_sub   = ok && inst.r3.opcode == op_sub_w;
    assign is_and   = ok && inst.r3.opcode == op_and;
    assign is_or    = ok && inst.r3.opcode == op_or;
    assign is_xor   = ok && inst.r3.opcode == op_xor;
    assign is_addi  = ok && inst.ri12.opcode == op_addi_w;
    assign is_andi  = ok && inst.ri12.opcode == op_andi;
    assign is_ori   = ok && inst.ri12.opcode == op_ori;
    assign is_lu12i = ok && inst.ri20.opcode == op_lu12i_w;
    assign is_beq   = ok && inst.ri16.opcode == op_beq;
    assign is_bne   = ok && inst.ri16.opcode == op_bne;
    assign is_b     = ok && inst.ri16.opcode == op_b;
    assign is_jirl  = ok && inst.ri16.opcode == op_jirl;

    assign simm12    = {{20{inst.ri12.imm12[11]}}, inst.ri12.imm12};
    assign zimm12    = {20'd0, inst.ri12.imm12};
    assign lu12i_imm = {inst.ri20.si20, 12'd0};
    assign offs16_sh = {{14{inst.ri16.offs16[15]}}, inst.ri16.offs16, 2'b00};
    assign offs26_sh = {{4{inst.ri16.rj[4]}}, inst.ri16.rj, inst.ri16.rd,
                        inst.ri16.offs16, 2'b00};

    // beq/bne compare rj with rd while 3R ops read rk
    assign rf_raddr1 = inst.r3.rj;
    assign rf_raddr2 = (is_beq || is_bne) ? inst.r3.rd : inst.r3.rk;

    assign use_r2 = is_add || is_sub || is_and || is_or || is_xor || is_beq || is_bne;
    assign use_rj = use_r2 || is_addi || is_andi || is_ori || is_jirl;

    // no forwarding so wait until the producer has left wb
    assign hazard =
        (use_rj && rf_raddr1 != 5'd0 &&
         ((exe_dest_info.we && exe_dest_info.addr == rf_raddr1) ||
          (wb_rf.we && wb_rf.addr == rf_raddr1))) ||
        (use_r2 && rf_raddr2 != 5'd0 &&
         ((exe_dest_info.we && exe_dest_info.addr == rf_raddr2) ||
          (wb_rf.we && wb_rf.addr == rf_raddr2)));

    assign id_ready_go     = !hazard;
    assign id_allowin      = !id_valid || (id_ready_go && exe_allowin);
    assign id_to_exe_valid = id_valid && id_ready_go;

    assign src_eq  = rf_rdata1 == rf_rdata2;
    assign br_cond = (is_beq && src_eq) || (is_bne && !src_eq) || is_b || is_jirl;

    assign br.br_taken  = id_valid && id_ready_go && br_cond;
    assign br.br_target = is_jirl ? rf_rdata1 + offs16_sh :
                          is_b    ? id_bus.pc + offs26_sh :
                                    id_bus.pc + offs16_sh;

    always_comb begin
        dec_alu_op = alu_add;                   // also the no-op default
        if (is_sub) begin
            dec_alu_op = alu_sub;
        end else if (is_and || is_andi) begin
            dec_alu_op = alu_and;
        end else if (is_or || is_ori) begin
            dec_alu_op = alu_or;
        end else if (is_xor) begin
            dec_alu_op = alu_xor;
        end else if (is_lu12i || is_jirl) begin
            dec_alu_op = alu_pass_b;
        end
    end

    assign dec_src_b = is_addi           ? simm12 :
                       (is_andi||is_ori) ? zimm12 :
                       is_lu12i          ? lu12i_imm :
                       is_jirl           ? id_bus.pc + 32'd4 :   // link
                                           rf_rdata2;

    assign dec_rf_we = is_add || is_sub || is_and || is_or || is_xor ||
                       is_addi || is_andi || is_ori || is_lu12i || is_jirl;

    assign id_to_exe_bus = '{
        pc:     id_bus.pc,
        alu_op: dec_alu_op,
        src_a:  rf_rdata1,
        src_b:  dec_src_b,
        rf_we:  dec_rf_we,
        dest:   inst.r3.rd,
        adef:   id_bus.adef
    };

    a_br_valid: assert property (@(posedge clk) disable iff (!resetn)
        !id_valid |-> !br.br_taken);

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  rf_wr_t      wr,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (wr.we && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // r0 reads as zero whatever the array holds
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

// File: source/exe_stage.sv
`timescale 1ns/1ps

module exe_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        id_to_exe_valid,
    input  id_exe_bus_t id_to_exe_bus,
    input  logic        wb_allowin,
    input  logic        flush,
    output logic        exe_allowin,
    output rf_wr_t      exe_dest_info,
    output logic        exe_to_wb_valid,
    output exe_wb_bus_t exe_to_wb_bus
);

    logic        exe_valid;
    id_exe_bus_t exe_bus;
    logic [31:0] alu_result;

    assign exe_allowin = !exe_valid || wb_allowin;   // single-cycle ALU

    always_ff @(posedge clk) begin
        if (!resetn || flush) begin
            exe_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_valid <= id_to_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_exe_valid && exe_allowin) begin
            exe_bus <= id_to_exe_bus;
        end
    end

    always_comb begin
        case (exe_bus.alu_op)
            alu_add: alu_result = exe_bus.src_a + exe_bus.src_b;
            alu_sub: alu_result = exe_bus.src_a - exe_bus.src_b;
            alu_and: alu_result = exe_bus.src_a & exe_bus.src_b;
            alu_or:  alu_result = exe_bus.src_a | exe_bus.src_b;
            alu_xor: alu_result = exe_bus.src_a ^ exe_bus.src_b;
            default: alu_result = exe_bus.src_b;       // lu12i value or jirl link
        endcase
    end

    // pending write seen by decode
    assign exe_dest_info = '{
        we:   exe_valid && exe_bus.rf_we,
        addr: exe_bus.dest,
        data: alu_result
    };

    assign exe_to_wb_valid = exe_valid;
    assign exe_to_wb_bus   = '{
        pc:     exe_bus.pc,
        result: alu_result,
        rf_we:  exe_bus.rf_we,
        dest:   exe_bus.dest,
        adef:   exe_bus.adef
    };

endmodule

// File: source/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic        exe_to_wb_valid,
    input  exe_wb_bus_t exe_to_wb_bus,
    output logic        wb_allowin,
    output rf_wr_t      wb_rf,
    output flush_t      wb_to_if_bus,
    output logic        debug_wb_valid,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata,
    output logic        debug_wb_excp
);

    logic        wb_valid;
    exe_wb_bus_t wb_bus;
    logic        excp;

    assign wb_allowin = 1'b1;          // retires every cycle

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exe_to_wb_valid && !excp;   // younger slot dies with the flush
        end
    end

    always_ff @(posedge clk) begin
        if (exe_to_wb_valid) begin
            wb_bus <= exe_to_wb_bus;
        end
    end

    assign excp = wb_valid && wb_bus.adef;

    assign wb_rf = '{
        we:   wb_valid && wb_bus.rf_we && !wb_bus.adef,
        addr: wb_bus.dest,
        data: wb_bus.result
    };

    assign wb_to_if_bus = '{flush: excp, target: excp_entry};

    assign debug_wb_valid    = wb_valid;
    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_we    = wb_rf.we;
    assign debug_wb_rf_wnum  = wb_bus.dest;
    assign debug_wb_rf_wdata = wb_bus.result;
    assign debug_wb_excp     = excp;

    // faulting instruction writes nothing
    a_flush_quiet: assert property (@(posedge clk) disable iff (!resetn)
        wb_to_if_bus.flush |-> !wb_rf.we);

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,
    input  logic [31:0] inst_sram_rdata,
    output logic        inst_sram_en,
    output logic [31:0] inst_sram_addr,
    output logic        debug_wb_valid,
    output logic [31:0] debug_wb_pc,
    output logic        debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata,
    output logic        debug_wb_excp
);

    logic        id_allowin;
    logic        exe_allowin;
    logic        wb_allowin;
    logic        if_to_id_valid;
    logic        id_to_exe_valid;
    logic        exe_to_wb_valid;
    if_id_bus_t  if_to_id_bus;
    id_exe_bus_t id_to_exe_bus;
    exe_wb_bus_t exe_to_wb_bus;
    br_bus_t     br;
    flush_t      wb_to_if_bus;
    rf_wr_t      exe_dest_info;
    rf_wr_t      wb_rf;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;

    if_stage u_if (
        .clk             (clk),
        .resetn          (resetn),
        .id_allowin      (id_allowin),
        .br              (br),
        .wb_to_if_bus    (wb_to_if_bus),
        .inst_sram_rdata (inst_sram_rdata),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .if_to_id_valid  (if_to_id_valid),
        .if_to_id_bus    (if_to_id_bus)
    );

    id_stage u_id (
        .clk             (clk),
        .resetn          (resetn),
        .if_to_id_valid  (if_to_id_valid),
        .if_to_id_bus    (if_to_id_bus),
        .exe_allowin     (exe_allowin),
        .exe_dest_info   (exe_dest_info),
        .wb_rf           (wb_rf),
        .rf_rdata1       (rf_rdata1),
        .rf_rdata2       (rf_rdata2),
        .flush           (wb_to_if_bus.flush),
        .id_allowin      (id_allowin),
        .br              (br),
        .rf_raddr1       (rf_raddr1),
        .rf_raddr2       (rf_raddr2),
        .id_to_exe_valid (id_to_exe_valid),
        .id_to_exe_bus   (id_to_exe_bus)
    );

    regfile u_rf (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .wr     (wb_rf),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    exe_stage u_exe (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_exe_valid (id_to_exe_valid),
        .id_to_exe_bus   (id_to_exe_bus),
        .wb_allowin      (wb_allowin),
        .flush           (wb_to_if_bus.flush),
        .exe_allowin     (exe_allowin),
        .exe_dest_info   (exe_dest_info),
        .exe_to_wb_valid (exe_to_wb_valid),
        .exe_to_wb_bus   (exe_to_wb_bus)
    );

    wb_stage u_wb (
        .clk               (clk),
        .resetn            (resetn),
        .exe_to_wb_valid   (exe_to_wb_valid),
        .exe_to_wb_bus     (exe_to_wb_bus),
        .wb_allowin        (wb_allowin),
        .wb_rf             (wb_rf),
        .wb_to_if_bus      (wb_to_if_bus),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_excp     (debug_wb_excp)
    );

endmodule

// File: verification/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top import cpu_pkg::*; ();

    logic        clk;
    logic        resetn;
    logic [31:0] inst_sram_rdata;
    logic        inst_sram_en;
    logic [31:0] inst_sram_addr;
    logic        debug_wb_valid;
    logic [31:0] debug_wb_pc;
    logic        debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;
    logic        debug_wb_excp;

    logic [31:0] imem [1024];       // 4 KiB from reset_pc with the handler at excp_entry
    logic [31:0] sram_addr_q;
    logic [31:0] wr_pc;             // generator write pointer
    logic [31:0] item_pc [301];     // start of each random item plus the end loop
    int          item_kind [300];
    exe_wb_bus_t exp_q [$];
    int          value_errs;
    int          other_errs;
    int          checked;

    cpu_top dut0 (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_rdata   (inst_sram_rdata),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_excp     (debug_wb_excp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // opcode field 6'h3f is outside the subset
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return {6'h3f, addr[27:2] ^ {addr[31:28], 22'd0}};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - reset_pc;
        if (off < 32'd4096) begin
            return imem[off[11:2]];
        end
        return fill_word(addr);
    endfunction

    // synchronous SRAM latches the address on the rising edge and drives data on the falling one
    initial begin
        sram_addr_q = reset_pc;
        forever begin
            @(posedge clk);
            if (inst_sram_en) begin
                sram_addr_q <= inst_sram_addr;
            end
        end
    end

    initial begin
        inst_sram_rdata = 32'd0;
        forever begin
            @(negedge clk);
            inst_sram_rdata <= read_word(sram_addr_q);   // held while en is low
        end
    end

    function automatic logic [4:0] rand_reg();
        logic [31:0] v;
        v = $urandom;
        return {2'b00, v[2:0]};       // r0..r7 only for lots of dependencies
    endfunction

    function automatic logic [16:0] pick_3r(input logic [31:0] n);
        case (n % 5)
            0: return op_add_w;
            1: return op_sub_w;
            2: return op_and;
            3: return op_or;
            default: return op_xor;
        endcase
    endfunction

    function automatic logic [9:0] pick_ri12(input logic [31:0] n);
        case (n % 3)
            0: return op_addi_w;
            1: return op_andi;
            default: return op_ori;
        endcase
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] op,
                                           input logic [4:0] rk, rj, rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [11:0] imm,
                                             input logic [4:0] rj, rd);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] enc_ri16(input logic [5:0] op, input logic [15:0] offs,
                                             input logic [4:0] rj, rd);
        return {op, offs, rj, rd};
    endfunction

    function automatic logic [31:0] enc_lu12i(input logic [19:0] si20, input logic [4:0] rd);
        return {op_lu12i_w, si20, rd};
    endfunction

    function automatic logic [31:0] enc_b(input logic [25:0] offs);
        return {op_b, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] word_offs(input logic [31:0] from_pc, to_pc);
        return (to_pc - from_pc) >> 2;   // forward only
    endfunction

    task automatic emit(input logic [31:0] w);
        logic [31:0] off;
        off = wr_pc - reset_pc;
        imem[off[11:2]] = w;
        wr_pc = wr_pc + 32'd4;
    endtask

    task automatic load_r29(input logic [31:0] value);
        emit(enc_lu12i(value[31:12], 5'd29));
        emit(enc_ri12(op_ori, value[11:0], 5'd29, 5'd29));
    endtask

    task automatic build_program();
        logic [31:0] v;
        logic [31:0] v2;
        logic [31:0] cursor;
        logic [31:0] tgt;
        logic [31:0] offs;
        logic [5:0]  bop;
        int          j;
        foreach (imem[i]) begin
            imem[i] = fill_word(reset_pc + 32'(i) * 32'd4);
        end
        wr_pc = reset_pc;
        for (int r = 1; r < 8; r++) begin
            v = $urandom;
            emit(enc_lu12i(v[31:12], 5'(r)));
            emit(enc_ri12(op_ori, v[11:0], 5'(r), 5'(r)));
        end
        emit(enc_ri12(op_addi_w, 12'd0, 5'd0, 5'd28));   // fault counter
        cursor = wr_pc;
        for (int i = 0; i < 300; i++) begin
            v = $urandom % 100;
            item_kind[i] = (v < 45) ? 0 :
                           (v < 65) ? 1 :
                           (v < 72) ? 2 :
                           (v < 86) ? 3 :
                           (v < 91) ? 4 :
                           (v < 96) ? 5 : 6;
            item_pc[i] = cursor;
            cursor = cursor + ((item_kind[i] >= 5) ? 32'd12 : 32'd4);
        end
        item_pc[300] = cursor;
        for (int i = 0; i < 300; i++) begin
            v  = $urandom;
            v2 = $urandom;
            j  = i + 1 + int'(v[1:0]);
            if (j > 300) begin
                j = 300;
            end
            tgt  = item_pc[j];
            offs = word_offs(item_pc[i], tgt);
            bop  = v2[0] ? op_beq : op_bne;
            case (item_kind[i])
                0: emit(enc_3r(pick_3r(v2), rand_reg(), rand_reg(), rand_reg()));
                1: emit(enc_ri12(pick_ri12(v2), v2[31:20], rand_reg(), rand_reg()));
                2: emit(enc_lu12i(v2[31:12], rand_reg()));
                3: emit(enc_ri16(bop, offs[15:0], rand_reg(), rand_reg()));
                4: emit(enc_b(offs[25:0]));
                5: begin
                    load_r29(tgt);
                    emit(enc_ri16(op_jirl, 16'd0, 5'd29, rand_reg()));
                end
                default: begin
                    load_r29(item_pc[i+1] | 32'd1);   // low bit set so the fetch faults
                    emit(enc_ri16(op_jirl, 16'd0, 5'd29, rand_reg()));
                end
            endcase
        end
        emit(enc_b(26'd0));                               // b to self ends the program
        if (item_pc[300] + 32'd4 > excp_entry) begin
            $display("generated program runs into the exception handler");
            other_errs++;
        end
        // handler counts faults and returns to the instruction after the jirl
        wr_pc = excp_entry;
        emit(enc_ri12(op_addi_w, 12'd1, 5'd28, 5'd28));
        emit(enc_3r(op_xor, 5'd28, 5'd1, 5'd1));
        emit(enc_b(26'd2));
        emit(enc_ri12(op_addi_w, 12'd5, 5'd1, 5'd1));     // skipped
        emit(enc_ri12(op_addi_w, 12'hfff, 5'd29, 5'd29)); // resume label
        emit(enc_ri16(op_jirl, 16'd0, 5'd29, 5'd0));
    endtask

    // in-order ISA model with one entry per expected retirement
    task automatic run_model();
        logic [31:0] mrf [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a, b, d, nxt, val;
        logic [31:0] s16;
        logic        we;
        logic        done;
        exe_wb_bus_t rec;
        int          steps;
        foreach (mrf[r]) begin
            mrf[r] = 32'd0;
        end
        pc    = reset_pc;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4000) begin
            steps++;
            if (pc[1:0] != 2'b00) begin
                rec = '{pc: pc, result: 32'd0, rf_we: 1'b0, dest: 5'd0, adef: 1'b1};
                exp_q.push_back(rec);
                pc = excp_entry;
            end else begin
                w   = read_word(pc);
                a   = mrf[w[9:5]];
                b   = mrf[w[14:10]];
                d   = mrf[w[4:0]];
                s16 = {{14{w[25]}}, w[25:10], 2'b00};
                nxt = pc + 32'd4;
                val = 32'd0;
                we  = 1'b1;
                if (w[31:15] == op_add_w)
                    val = a + b;
                else if (w[31:15] == op_sub_w)
                    val = a - b;
                else if (w[31:15] == op_and)
                    val = a & b;
                else if (w[31:15] == op_or)
                    val = a | b;
                else if (w[31:15] == op_xor)
                    val = a ^ b;
                else if (w[31:22] == op_addi_w)
                    val = a + {{20{w[21]}}, w[21:10]};
                else if (w[31:22] == op_andi)
                    val = a & {20'd0, w[21:10]};
                else if (w[31:22] == op_ori)
                    val = a | {20'd0, w[21:10]};
                else if (w[31:25] == op_lu12i_w)
                    val = {w[24:5], 12'd0};
                else if (w[31:26] == op_jirl) begin
                    val = pc + 32'd4;
                    nxt = a + s16;     // old rj even when rd == rj
                end else begin
                    we = 1'b0;         // branches and unknown words write nothing
                    if (w[31:26] == op_beq && a == d)
                        nxt = pc + s16;
                    if (w[31:26] == op_bne && a != d)
                        nxt = pc + s16;
                    if (w[31:26] == op_b)
                        nxt = pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
                end
                rec = '{pc: pc, result: val, rf_we: we, dest: w[4:0], adef: 1'b0};
                exp_q.push_back(rec);
                if (we && w[4:0] != 5'd0) begin
                    mrf[w[4:0]] = val;
                end
                done = (pc == item_pc[300]);
                pc = nxt;
            end
        end
        if (!done) begin
            $display("reference model never reached the end of the program");
            other_errs++;
        end
    endtask

    task automatic check_retire(input exe_wb_bus_t exp_ret, input exe_wb_bus_t got_ret);
        if (got_ret.pc !== exp_ret.pc) begin
            $display("error debug_wb_pc exp=%h got=%h", exp_ret.pc, got_ret.pc);
            value_errs++;
        end
        if (got_ret.rf_we !== exp_ret.rf_we) begin
            $display("error debug_wb_rf_we exp=%h got=%h at pc %h",
                     exp_ret.rf_we, got_ret.rf_we, exp_ret.pc);
            value_errs++;
        end
        if (exp_ret.rf_we && got_ret.dest !== exp_ret.dest) begin
            $display("error debug_wb_rf_wnum exp=%h got=%h at pc %h",
                     exp_ret.dest, got_ret.dest, exp_ret.pc);
            value_errs++;
        end
        if (exp_ret.rf_we && got_ret.result !== exp_ret.result) begin
            $display("error debug_wb_rf_wdata exp=%h got=%h at pc %h",
                     exp_ret.result, got_ret.result, exp_ret.pc);
            value_errs++;
        end
    endtask

    task automatic check_excp(input exe_wb_bus_t exp_ret, input exe_wb_bus_t got_ret);
        if (got_ret.adef !== exp_ret.adef) begin
            $display("error debug_wb_excp exp=%h got=%h at pc %h",
                     exp_ret.adef, got_ret.adef, exp_ret.pc);
            value_errs++;
        end
        if (exp_ret.adef && got_ret.pc !== exp_ret.pc) begin
            $display("error debug_wb_pc exp=%h got=%h on the faulting fetch",
                     exp_ret.pc, got_ret.pc);
            value_errs++;
        end
        if (exp_ret.adef && got_ret.rf_we !== 1'b0) begin
            $display("error debug_wb_rf_we exp=0 got=%h on the faulting fetch", got_ret.rf_we);
            value_errs++;
        end
    endtask

    task automatic wait_retire(output logic timed_out);
        int n;
        n = 0;
        timed_out = 1'b0;
        do begin
            @(negedge clk);
            n++;
        end while (!debug_wb_valid && n < 100);
        if (!debug_wb_valid) begin
            timed_out = 1'b1;
            $display("no retirement within 100 cycles, %0d still expected", exp_q.size());
            other_errs++;
        end
    endtask

    initial begin
        exe_wb_bus_t exp_ret;
        exe_wb_bus_t got_ret;
        logic        timed_out;
        resetn     = 1'b0;
        value_errs = 0;
        other_errs = 0;
        checked    = 0;
        void'($urandom(32'h6913));
        build_program();
        run_model();
        repeat (8) @(negedge clk);
        resetn    = 1'b1;
        timed_out = 1'b0;
        while (exp_q.size() > 0 && !timed_out) begin
            wait_retire(timed_out);
            if (!timed_out) begin
                exp_ret = exp_q.pop_front();
                got_ret = '{pc: debug_wb_pc, result: debug_wb_rf_wdata,
                            rf_we: debug_wb_rf_we, dest: debug_wb_rf_wnum,
                            adef: debug_wb_excp};
                check_excp(exp_ret, got_ret);
                if (!exp_ret.adef) begin
                    check_retire(exp_ret, got_ret);
                end
                checked++;
            end
        end
        $display("checked %0d retirements, %0d value errors, %0d other errors",
                 checked, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
source/cpu_pkg.sv
source/if_stage.sv
source/id_stage.sv
source/regfile.sv
source/exe_stage.sv
source/wb_stage.sv
source/cpu_top.sv
verification/tb_cpu_top.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_cpu_top -f flist.f -Mdir obj_dir
	./obj_dir/Vtb_cpu_top | awk '{ print } /^Result: PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
